// File: bench/golden_vectors.txt
# op addr wdata expect, all hex. HW/CW write, HR/CR read and compare with expect.
# host addr: exp 23, region 22:20, bank 19:18, page 10, offset 9:0. cpu addr: 16 bits.
HW 000000 a5 00
HW 0003ff 5a 00
HW 040000 11 00
HW 0403ff 22 00
HW 080000 33 00
HW 0803ff 44 00
HW 0c0000 55 00
HW 0c03ff 66 00
HR 000000 00 a5
HR 0003ff 00 5a
HR 040000 00 11
HR 0403ff 00 22
HR 080000 00 33
HR 0803ff 00 44
HR 0c0000 00 55
HR 0c03ff 00 66
HW 800010 c3 00
HW 800420 3c 00
HR 080010 00 c3
HR 0c0020 00 3c
CR 000000 00 a5
CR 000fff 00 5a
CR 002010 00 c3
CR 003c20 00 3c
CR 004000 00 ff
CR 00c123 00 ff
CW 000005 77 00
HR 000005 00 77
CW 001c06 88 00
HR 040006 00 88
CW 002010 99 00
HR 080010 00 c3
CW 003000 99 00
HR 0c0000 00 55
HW 100000 12 00
HR 100000 00 00
HR 7c0123 00 00

// File: bench/tb_memory_board.sv
`timescale 1ns/1ps

module tb_memory_board
   import board_pkg::*;
   import host_pkg::*;
();

   localparam int TIMEOUT    = 20;
   localparam int RANDOM_OPS = 200;

   logic        clk;
   logic        reset_i;
   host_req_t   host_req;
   host_rsp_t   host_rsp;
   cpu_req_t    cpu_req;
   cpu_rsp_t    cpu_rsp;
   int          check_count = 0;
   int          mismatch_count = 0;
   int          fault_count = 0;
   integer      seed;
   logic [7:0]  model [0:4095];
   logic [11:0] written_q[$];

   memory_board u_dut (
      .clk        (clk),
      .reset_i    (reset_i),
      .host_req_i (host_req),
      .host_rsp_o (host_rsp),
      .cpu_req_i  (cpu_req),
      .cpu_rsp_o  (cpu_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [7:0] got,
                              input logic [7:0] expected);
      check_count++;
      if (got !== expected) begin
         mismatch_count++;
         $display("FAIL %s got 0x%02h expected 0x%02h", name, got, expected);
      end
   endtask

   task automatic host_access(input logic we, input logic [23:0] adr, input logic [7:0] wdat,
                              output logic [7:0] rdat, output bit ok);
      int waited;
      waited = 0;
      ok = 1'b0;
      rdat = 8'h00;
      @(posedge clk);
      host_req.cyc <= 1'b1;
      host_req.stb <= 1'b1;
      host_req.we  <= we;
      host_req.adr <= adr;
      host_req.dat <= wdat;
      while (!ok && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
         if (host_rsp.ack) begin
            ok = 1'b1;
            rdat = host_rsp.dat;
         end
      end
      // drop the strobe at the end of the ack cycle.
      @(posedge clk);
      host_req.cyc <= 1'b0;
      host_req.stb <= 1'b0;
      host_req.we  <= 1'b0;
      if (!ok) begin
         fault_count++;
         $display("error: host cycle at %06h got no ack within %0d cycles", adr, TIMEOUT);
      end else begin
         repeat (2) begin
            @(negedge clk);
            if (host_rsp.ack) begin
               fault_count++;
               $display("error: host cycle at %06h was acknowledged more than once", adr);
            end
         end
      end
   endtask

   task automatic cpu_write(input logic [15:0] addr, input logic [7:0] wdat);
      @(posedge clk);
      cpu_req.wr    <= 1'b1;
      cpu_req.addr  <= addr;
      cpu_req.wdata <= wdat;
      @(posedge clk);
      cpu_req.wr <= 1'b0;
   endtask

   task automatic cpu_read_check(input logic [15:0] addr, input logic [7:0] expected);
      int waited;
      bit seen;
      waited = 0;
      seen = 1'b0;
      @(posedge clk);
      cpu_req.rd   <= 1'b1;
      cpu_req.addr <= addr;
      @(posedge clk);
      cpu_req.rd <= 1'b0;
      while (!seen && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
         if (cpu_rsp.rvalid) begin
            seen = 1'b1;
            check_value($sformatf("cpu_rsp_o.rdata @%04h", addr), cpu_rsp.rdata, expected);
         end
      end
      if (!seen) begin
         fault_count++;
         $display("error: cpu read at %04h got no rvalid within %0d cycles", addr, TIMEOUT);
      end
   endtask

   task automatic replay_golden();
      int          fd;
      int          n;
      string       op;
      string       rest;
      logic [23:0] addr;
      logic [7:0]  wdat;
      logic [7:0]  expected;
      logic [7:0]  rdat;
      bit          ok;
      fd = $fopen("bench/golden_vectors.txt", "r");
      if (fd == 0) begin
         fault_count++;
         $display("error: could not open bench/golden_vectors.txt");
         return;
      end
      while (!$feof(fd)) begin
         n = $fscanf(fd, "%s", op);
         if (n != 1) begin
            continue;
         end
         if (op.substr(0, 0) == "#") begin
            n = $fgets(rest, fd);
         end else if ($fscanf(fd, "%h %h %h", addr, wdat, expected) != 3) begin
            fault_count++;
            $display("error: golden line for %s has missing fields", op);
         end else if (op == "HW") begin
            host_access(1'b1, addr, wdat, rdat, ok);
         end else if (op == "HR") begin
            host_access(1'b0, addr, 8'h00, rdat, ok);
            if (ok) begin
               check_value($sformatf("host_rsp_o.dat @%06h", addr), rdat, expected);
            end
         end else if (op == "CW") begin
            cpu_write(addr[15:0], wdat);
         end else if (op == "CR") begin
            cpu_read_check(addr[15:0], expected);
         end else begin
            fault_count++;
            $display("error: unknown golden operation %s", op);
         end
      end
      $fclose(fd);
   endtask

   // host loads a random byte, then the cpu reads some loaded byte back.
   task automatic random_pass();
      logic [1:0]  bank;
      logic [9:0]  off;
      logic [7:0]  data;
      logic [1:0]  mirror;
      logic [11:0] slot;
      logic [7:0]  rdat;
      int          pick;
      bit          ok;
      for (int i = 0; i < RANDOM_OPS; i++) begin
         bank = 2'($random(seed));
         off  = 10'($random(seed));
         data = 8'($random(seed));
         host_access(1'b1, {4'h0, bank, 8'h00, off}, data, rdat, ok);
         model[{bank, off}] = data;
         written_q.push_back({bank, off});
         pick = $unsigned($random(seed)) % written_q.size();
         slot = written_q[pick];
         mirror = 2'($random(seed));
         cpu_read_check({2'b00, slot[11:10], mirror, slot[9:0]}, model[slot]);
      end
   endtask

   initial begin
      seed = 32'h7ecf;
      reset_i  <= 1'b1;
      host_req <= '0;
      cpu_req  <= '0;
      repeat (3) @(posedge clk);
      reset_i <= 1'b0;
      replay_golden();
      random_pass();
      repeat (2) @(posedge clk);
      $display("checks %0d, mismatches %0d, other errors %0d",
               check_count, mismatch_count, fault_count);
      if (mismatch_count == 0 && fault_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: list.f
source/board_pkg.sv
source/host_pkg.sv
source/bus_decoder.sv
source/byte_bank.sv
source/read_merge.sv
source/memory_board.sv
bench/tb_memory_board.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_memory_board -o sim_memory_board
./obj_dir/sim_memory_board | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// File: source/board_pkg.sv
package board_pkg;

   // bank geometry.
   localparam int NUM_BANKS      = 4;
   localparam int BANK_ADDR_BITS = 10;
   localparam int BANK_SEL_BITS  = $clog2(NUM_BANKS);

   // banks 0 and 1 are RAM, 2 and 3 are ROM.
   localparam logic [NUM_BANKS-1:0] BANK_CPU_WRITABLE = 4'b0011;

   // cpu map. 15:14 must be zero, 13:12 pick the bank.
   localparam int CPU_WIN_LSB  = 14;
   localparam int CPU_BANK_LSB = 12;

   // nobody drives the cpu data bus.
   localparam logic [7:0] CPU_OPEN_BUS = 8'hff;

   typedef struct packed {
      logic        rd;
      logic        wr;
      logic [15:0] addr;
      logic [7:0]  wdata;
   } cpu_req_t;

   typedef struct packed {
      logic       rvalid;
      logic [7:0] rdata;
   } cpu_rsp_t;

   typedef struct packed {
      logic [NUM_BANKS-1:0] host_stb;
      logic [NUM_BANKS-1:0] cpu_cs;
   } bank_sel_t;

endpackage

// File: source/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder
   import board_pkg::*;
   import host_pkg::*;
(
   input  logic      clk,
   input  logic      reset_i,
   input  host_req_t host_req_i,
   input  cpu_req_t  cpu_req_i,
   output bank_sel_t sel_o,
   output logic      null_stb_o
);

   logic                 host_active;
   logic                 host_pending;
   logic                 host_first;
   logic [NUM_BANKS-1:0] host_map;
   logic [NUM_BANKS-1:0] cpu_map;

   assign host_active = host_req_i.cyc & host_req_i.stb;
   assign host_first  = host_active & ~host_pending;

   // strobe seen last cycle, so this one was already handed out.
   always_ff @(posedge clk) begin
      if (reset_i) begin
         host_pending <= 1'b0;
      end else begin
         host_pending <= host_active;
      end
   end

   always_comb begin
      host_map = '0;
      if (!host_req_i.adr.console.exp) begin
         if (host_req_i.adr.console.region == 3'd0) begin
            host_map[host_req_i.adr.console.bank] = 1'b1;
         end
      end else begin
         // expansion page 0 and 1 land in banks 2 and 3.
         host_map[{1'b1, host_req_i.adr.expansion.page}] = 1'b1;
      end
   end

   always_comb begin
      cpu_map = '0;
      if ((cpu_req_i.rd || cpu_req_i.wr) && cpu_req_i.addr[15:CPU_WIN_LSB] == '0) begin
         cpu_map[cpu_req_i.addr[CPU_BANK_LSB +: BANK_SEL_BITS]] = 1'b1;
      end
   end

   assign sel_o = '{
      host_stb: host_map & {NUM_BANKS{host_first}},
      cpu_cs:   cpu_map
   };

   assign null_stb_o = host_first & ~(|host_map);

   // master holds the request until ack.
   a_host_stable: assert property (@(posedge clk) disable iff (reset_i)
      (host_active && host_pending) |-> ($stable(host_req_i.adr) && $stable(host_req_i.we)));

   // a cpu cycle is a read or a write, not both.
   a_cpu_rd_wr: assert property (@(posedge clk) disable iff (reset_i)
      !(cpu_req_i.rd && cpu_req_i.wr));

endmodule

// File: source/byte_bank.sv
`timescale 1ns/1ps

module byte_bank
   import board_pkg::*;
#(
   parameter bit writable = 1'b0
) (
   input  logic                      clk,
   input  logic                      reset_i,
   input  logic                      host_stb_i,
   input  logic                      host_we_i,
   input  logic [BANK_ADDR_BITS-1:0] host_off_i,
   input  logic [7:0]                host_dat_i,
   output logic [7:0]                host_dat_o,
   output logic                      host_ack_o,
   input  logic                      cpu_cs_i,
   input  logic                      cpu_wr_i,
   input  logic [BANK_ADDR_BITS-1:0] cpu_off_i,
   input  logic [7:0]                cpu_dat_i,
   output logic [7:0]                cpu_dat_o,
   output logic                      cpu_valid_o
);

   logic [7:0] mem [0:(2**BANK_ADDR_BITS)-1];
   logic       host_wr_en;
   logic       cpu_wr_en;
   logic       cpu_rd_en;

   assign host_wr_en = host_stb_i & host_we_i;
   assign cpu_wr_en  = cpu_cs_i & cpu_wr_i & writable;
   assign cpu_rd_en  = cpu_cs_i & ~cpu_wr_i;

   // host owns the write port when both want it.
   always_ff @(posedge clk) begin
      if (host_wr_en) begin
         mem[host_off_i] <= host_dat_i;
      end else if (cpu_wr_en) begin
         mem[cpu_off_i] <= cpu_dat_i;
      end
   end

   always_ff @(posedge clk) begin
      if (host_stb_i) begin
         host_dat_o <= mem[host_off_i];
      end
      if (cpu_rd_en) begin
         cpu_dat_o <= mem[cpu_off_i];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         host_ack_o  <= 1'b0;
         cpu_valid_o <= 1'b0;
      end else begin
         host_ack_o  <= host_stb_i;
         cpu_valid_o <= cpu_rd_en;
      end
   end

   // no second strobe lands in the ack cycle.
   a_single_ack: assert property (@(posedge clk) disable iff (reset_i)
      host_ack_o |-> !host_stb_i);

endmodule

// File: source/host_pkg.sv
package host_pkg;

   // returned by an unmapped host cycle.
   localparam logic [7:0] HOST_NULL_DAT = 8'h00;

   typedef struct packed {
      logic       exp;
      logic [2:0] region;
      logic [1:0] bank;
      logic [7:0] pad;
      logic [9:0] offset;
   } host_con_adr_t;

   typedef struct packed {
      logic        exp;
      logic [11:0] pad;
      logic        page;
      logic [9:0]  offset;
   } host_exp_adr_t;

   // same 24 bits, exp picks the view.
   typedef union packed {
      host_con_adr_t console;
      host_exp_adr_t expansion;
   } host_adr_u;

   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      host_adr_u  adr;
      logic [7:0] dat;
   } host_req_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } host_rsp_t;

endpackage

// File: source/memory_board.sv
`timescale 1ns/1ps

module memory_board
   import board_pkg::*;
   import host_pkg::*;
(
   input  logic      clk,
   input  logic      reset_i,
   input  host_req_t host_req_i,
   output host_rsp_t host_rsp_o,
   input  cpu_req_t  cpu_req_i,
   output cpu_rsp_t  cpu_rsp_o
);

   bank_sel_t                 sel;
   logic                      null_stb;
   logic [NUM_BANKS-1:0][7:0] bank_host_dat;
   logic [NUM_BANKS-1:0]      bank_host_ack;
   logic [NUM_BANKS-1:0][7:0] bank_cpu_dat;
   logic [NUM_BANKS-1:0]      bank_cpu_valid;
   logic [BANK_ADDR_BITS-1:0] host_off;
   logic [BANK_ADDR_BITS-1:0] cpu_off;

   // offset sits in the same bits in both views.
   assign host_off = host_req_i.adr.console.offset;
   assign cpu_off  = cpu_req_i.addr[BANK_ADDR_BITS-1:0];

   bus_decoder u_decoder (
      .clk        (clk),
      .reset_i    (reset_i),
      .host_req_i (host_req_i),
      .cpu_req_i  (cpu_req_i),
      .sel_o      (sel),
      .null_stb_o (null_stb)
   );

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      byte_bank #(
         .writable (BANK_CPU_WRITABLE[i])
      ) u_bank (
         .clk         (clk),
         .reset_i     (reset_i),
         .host_stb_i  (sel.host_stb[i]),
         .host_we_i   (host_req_i.we),
         .host_off_i  (host_off),
         .host_dat_i  (host_req_i.dat),
         .host_dat_o  (bank_host_dat[i]),
         .host_ack_o  (bank_host_ack[i]),
         .cpu_cs_i    (sel.cpu_cs[i]),
         .cpu_wr_i    (cpu_req_i.wr),
         .cpu_off_i   (cpu_off),
         .cpu_dat_i   (cpu_req_i.wdata),
         .cpu_dat_o   (bank_cpu_dat[i]),
         .cpu_valid_o (bank_cpu_valid[i])
      );
   end

   read_merge u_merge (
      .clk              (clk),
      .reset_i          (reset_i),
      .sel_i            (sel),
      .null_stb_i       (null_stb),
      .cpu_rd_i         (cpu_req_i.rd),
      .bank_host_dat_i  (bank_host_dat),
      .bank_host_ack_i  (bank_host_ack),
      .bank_cpu_dat_i   (bank_cpu_dat),
      .bank_cpu_valid_i (bank_cpu_valid),
      .host_rsp_o       (host_rsp_o),
      .cpu_rsp_o        (cpu_rsp_o)
   );

endmodule

// File: source/read_merge.sv
`timescale 1ns/1ps

module read_merge
   import board_pkg::*;
   import host_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset_i,
   input  bank_sel_t                     sel_i,
   input  logic                          null_stb_i,
   input  logic                          cpu_rd_i,
   input  logic [NUM_BANKS-1:0][7:0]     bank_host_dat_i,
   input  logic [NUM_BANKS-1:0]          bank_host_ack_i,
   input  logic [NUM_BANKS-1:0][7:0]     bank_cpu_dat_i,
   input  logic [NUM_BANKS-1:0]          bank_cpu_valid_i,
   output host_rsp_t                     host_rsp_o,
   output cpu_rsp_t                      cpu_rsp_o
);

   logic [NUM_BANKS-1:0] host_sel_q;
   logic                 null_q;
   logic                 cpu_rd_q;
   logic [7:0]           cpu_and;
   logic [7:0]           host_dat;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         host_sel_q <= '0;
         null_q     <= 1'b0;
         cpu_rd_q   <= 1'b0;
      end else begin
         host_sel_q <= sel_i.host_stb;
         null_q     <= null_stb_i;
         cpu_rd_q   <= cpu_rd_i;
      end
   end

   // wired-and bus, idle sources float high.
   always_comb begin
      cpu_and = CPU_OPEN_BUS;
      for (int i = 0; i < NUM_BANKS; i++) begin
         cpu_and = cpu_and & (bank_cpu_valid_i[i] ? bank_cpu_dat_i[i] : CPU_OPEN_BUS);
      end
   end

   always_comb begin
      host_dat = HOST_NULL_DAT;
      for (int i = 0; i < NUM_BANKS; i++) begin
         if (host_sel_q[i]) begin
            host_dat = bank_host_dat_i[i];
         end
      end
   end

   assign host_rsp_o = '{ack: (|bank_host_ack_i) | null_q, dat: host_dat};
   assign cpu_rsp_o  = '{rvalid: cpu_rd_q, rdata: cpu_and};

   a_one_ack: assert property (@(posedge clk) disable iff (reset_i)
      $onehot0(bank_host_ack_i));

endmodule
